//--- src/mdom_defs.svh
// mainboard slow-control constants
// widths, counts, serial timing and firmware version
`ifndef MDOM_DEFS_SVH
`define MDOM_DEFS_SVH

// firmware version word
`define MDOM_FW_VNUM 32'h0000_0004

// register bus geometry
`define MDOM_AXI_ADDR_W 8
`define MDOM_AXI_DATA_W 32

// serial frame lengths, adc3424 and ad5668
`define MDOM_ADC_SPI_BITS 24
`define MDOM_DAC_SPI_BITS 32
`define MDOM_SPI_MAX_BITS 32

// chip select counts
`define MDOM_N_ADC 6
`define MDOM_N_DAC_SYNC 9

// lclk cycles per half sclk period
`define MDOM_SPI_HALF 4

`define MDOM_LTC_W 48
`define MDOM_LED_STEP 16
`define MDOM_N_LED 3

`endif

//--- src/mdom_reg_pkg.sv
// register map of the slow-control bank
// byte addresses and bus response codes
package mdom_reg_pkg;

  // byte addresses, word aligned
  typedef enum logic [7:0] {
    VERSION   = 8'h00,
    ADC_RESET = 8'h04,
    // adc serial task registers
    ADC_SEL   = 8'h08,
    ADC_WDATA = 8'h0C,
    ADC_TASK  = 8'h10,
    ADC_RDATA = 8'h14,
    // dac serial task registers
    DAC_SEL   = 8'h18,
    DAC_WDATA = 8'h1C,
    DAC_TASK  = 8'h20,
    DAC_RDATA = 8'h24,
    // local time counter, read lo first
    LTC_LO    = 8'h28,
    LTC_HI    = 8'h2C
  } reg_addr_e;

  // bresp / rresp encodings
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

//--- src/mdom_serial_pkg.sv
// serial engine types
// frame FSM states and chip target index
package mdom_serial_pkg;

  // frame sequence
  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_SHIFT,
    S_DONE
  } spi_state_e;

  // target chip, 0..8 covers all dac syncs
  typedef logic [3:0] spi_tgt_t;

endpackage

//--- src/serial_ctrl_if.sv
// task link between register bank and one serial engine
// req held until the one-cycle ack at frame end
`timescale 1ns/1ps
`include "mdom_defs.svh"

interface serial_ctrl_if;
  import mdom_serial_pkg::*;

  logic req;
  logic ack;
  spi_tgt_t target;
  logic [`MDOM_SPI_MAX_BITS-1:0] wr_data;
  logic [`MDOM_SPI_MAX_BITS-1:0] rd_data;

  // register bank side
  modport ctrl (output req, output target, output wr_data, input ack, input rd_data);

  // frame engine side
  modport engine (input req, input target, input wr_data, output ack, output rd_data);

endinterface

//--- src/ltc_counter.sv
// 48-bit local time counter
// high word frozen on a low-word read so two reads form one value
`timescale 1ns/1ps
`include "mdom_defs.svh"

module ltc_counter (
  input  logic                   lclk,
  input  logic                   lclk_rst,
  input  logic                   i_snap,
  output logic [`MDOM_LTC_W-1:0] o_ltc,
  output logic [15:0]            o_ltc_hi_snap
);

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_ltc <= '0;
      o_ltc_hi_snap <= '0;
    end else begin
      o_ltc <= o_ltc + 1'b1;
      // same edge as the lo word capture
      if (i_snap) begin
        o_ltc_hi_snap <= o_ltc[`MDOM_LTC_W-1 -: 16];
      end
    end
  end

endmodule

//--- src/led_sweep.sv
// three-LED sweep pattern
// one lit LED bouncing end to end every MDOM_LED_STEP cycles
`timescale 1ns/1ps
`include "mdom_defs.svh"

module led_sweep (
  input  logic                   lclk,
  input  logic                   lclk_rst,
  output logic [`MDOM_N_LED-1:0] o_led
);

  localparam int L_STEP = `MDOM_LED_STEP;
  localparam int L_DW = $clog2(L_STEP);

  logic [L_DW-1:0] div_cnt;
  logic step;
  logic dir_down;

  assign step = (div_cnt == L_DW'(L_STEP - 1));

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      div_cnt <= '0;
      dir_down <= 1'b0;
      o_led <= `MDOM_N_LED'(1);
    end else begin
      div_cnt <= step ? '0 : div_cnt + 1'b1;
      if (step) begin
        // turn around at either end
        if (!dir_down && o_led[`MDOM_N_LED-1]) begin
          dir_down <= 1'b1;
          o_led <= o_led >> 1;
        end else if (dir_down && o_led[0]) begin
          dir_down <= 1'b0;
          o_led <= o_led << 1;
        end else begin
          o_led <= dir_down ? (o_led >> 1) : (o_led << 1);
        end
      end
    end
  end

  a_led_onehot: assert property (@(posedge lclk) disable iff (lclk_rst)
    $onehot(o_led));

endmodule

//--- src/spi_master.sv
// serial frame engine, MSB first, one shift register
// setup, P_BITS bits at 2*MDOM_SPI_HALF lclk each, one done cycle
// sample mid-bit, the first sclk edge away from the P_CPOL idle level
`timescale 1ns/1ps
`include "mdom_defs.svh"

module spi_master #(
  parameter int P_BITS = 24,
  parameter int P_N_CS = 6,
  parameter bit P_CPOL = 1'b0
) (
  input  logic              lclk,
  input  logic              lclk_rst,
  serial_ctrl_if.engine     ser,
  input  logic              i_miso,
  output logic              o_sclk,
  output logic              o_mosi,
  output logic [P_N_CS-1:0] o_cs_n
);
  import mdom_serial_pkg::*;

  localparam int L_HALF = `MDOM_SPI_HALF;
  localparam int L_PER = 2 * L_HALF;
  localparam int L_HW = $clog2(L_PER);
  localparam int L_BW = $clog2(P_BITS);

  spi_state_e state;
  logic [L_HW-1:0] half_cnt;
  logic [L_BW-1:0] bit_cnt;
  logic [P_BITS-1:0] sreg;
  logic rx_bit;
  logic frame_on;
  logic mid_bit;
  logic bit_end;

  assign mid_bit = (state == S_SHIFT) && (half_cnt == L_HW'(L_HALF - 1));
  assign bit_end = (state == S_SHIFT) && (half_cnt == L_HW'(L_PER - 1));

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      state <= S_IDLE;
      half_cnt <= '0;
      bit_cnt <= '0;
      o_sclk <= P_CPOL;
    end else begin
      case (state)
        S_IDLE: begin
          // first req cycle already counts as setup
          half_cnt <= ser.req ? L_HW'(1) : '0;
          bit_cnt <= '0;
          if (ser.req) begin
            state <= S_SETUP;
          end
        end
        S_SETUP: begin
          if (half_cnt == L_HW'(L_HALF - 1)) begin
            half_cnt <= '0;
            state <= S_SHIFT;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        S_SHIFT: begin
          if (mid_bit) begin
            o_sclk <= ~P_CPOL;
          end
          if (bit_end) begin
            // back to idle level, next bit starts
            o_sclk <= P_CPOL;
            half_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == L_BW'(P_BITS - 1)) begin
              state <= S_DONE;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // load on request, shift in the sampled bit at each bit boundary
  always_ff @(posedge lclk) begin
    if (state == S_IDLE && ser.req) begin
      sreg <= ser.wr_data[P_BITS-1:0];
    end else if (bit_end) begin
      sreg <= {sreg[P_BITS-2:0], rx_bit};
    end
    if (mid_bit) begin
      rx_bit <= i_miso;
    end
  end

  assign o_mosi = ((state == S_SETUP) || (state == S_SHIFT)) && sreg[P_BITS-1];
  assign ser.ack = (state == S_DONE);
  assign ser.rd_data = `MDOM_SPI_MAX_BITS'(sreg);

  // select released in the done cycle
  assign frame_on = (state == S_SETUP) || (state == S_SHIFT) ||
                    ((state == S_IDLE) && ser.req);

  // one-of-n active-low decode of target
  always_comb begin
    o_cs_n = '1;
    for (int i = 0; i < P_N_CS; i++) begin
      if (frame_on && (ser.target == spi_tgt_t'(i))) begin
        o_cs_n[i] = 1'b0;
      end
    end
  end

  a_one_cs: assert property (@(posedge lclk) disable iff (lclk_rst)
    $onehot0(~o_cs_n));

endmodule

//--- src/mdom_ctrl_regs.sv
// slow-control register bank, AXI4-Lite slave
// holds adc/dac task registers, adc reset, version and time readout
// illegal writes answer SLVERR and leave state untouched
`timescale 1ns/1ps
`include "mdom_defs.svh"

module mdom_ctrl_regs (
  input  logic                        lclk,
  input  logic                        lclk_rst,
  input  logic [`MDOM_AXI_ADDR_W-1:0] i_awaddr,
  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  logic [`MDOM_AXI_DATA_W-1:0] i_wdata,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  output logic [1:0]                  o_bresp,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  input  logic [`MDOM_AXI_ADDR_W-1:0] i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_arready,
  output logic [`MDOM_AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                  o_rresp,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output logic                        o_adc_reset,
  output logic                        o_ltc_snap,
  input  logic [`MDOM_LTC_W-1:0]      i_ltc,
  input  logic [15:0]                 i_ltc_hi_snap,
  serial_ctrl_if.ctrl                 adc_ser,
  serial_ctrl_if.ctrl                 dac_ser
);
  import mdom_reg_pkg::*;
  import mdom_serial_pkg::*;

  localparam int L_DW = `MDOM_AXI_DATA_W;

  logic aw_go;
  logic ar_go;
  logic wr_err;
  logic adc_start;
  logic dac_start;
  axi_resp_e rd_resp;
  logic [L_DW-1:0] rd_mux;
  spi_tgt_t adc_sel;
  spi_tgt_t dac_sel;
  logic [L_DW-1:0] adc_wdata;
  logic [L_DW-1:0] dac_wdata;
  logic [7:0] adc_rdata;
  logic [L_DW-1:0] dac_rdata;

  // write handshake, addr and data taken together
  assign aw_go = o_awready && i_awvalid && i_wvalid;
  assign o_wready = o_awready;

  // one read in flight
  assign o_arready = !o_rvalid;
  assign ar_go = i_arvalid && o_arready;

  // high word of the counter is frozen on a lo read
  assign o_ltc_snap = ar_go && (i_araddr == LTC_LO);

  // write decode and legality
  always_comb begin
    wr_err = 1'b0;
    adc_start = 1'b0;
    dac_start = 1'b0;
    case (reg_addr_e'(i_awaddr))
      VERSION, ADC_RESET, ADC_WDATA, ADC_RDATA: wr_err = 1'b0;
      DAC_WDATA, DAC_RDATA, LTC_LO, LTC_HI: wr_err = 1'b0;
      ADC_SEL: wr_err = (i_wdata >= `MDOM_N_ADC);
      DAC_SEL: wr_err = (i_wdata >= `MDOM_N_DAC_SYNC);
      ADC_TASK: begin
        // engine busy until ack clears req
        wr_err = adc_ser.req;
        adc_start = aw_go && !adc_ser.req && i_wdata[0];
      end
      DAC_TASK: begin
        wr_err = dac_ser.req;
        dac_start = aw_go && !dac_ser.req && i_wdata[0];
      end
      default: wr_err = 1'b1;
    endcase
  end

  // read mux, unmapped reads give zero
  always_comb begin
    rd_resp = RESP_OKAY;
    rd_mux = '0;
    case (reg_addr_e'(i_araddr))
      VERSION:   rd_mux = `MDOM_FW_VNUM;
      ADC_RESET: rd_mux = L_DW'(o_adc_reset);
      ADC_SEL:   rd_mux = L_DW'(adc_sel);
      ADC_WDATA: rd_mux = adc_wdata;
      // task reg reads back busy
      ADC_TASK:  rd_mux = L_DW'(adc_ser.req);
      ADC_RDATA: rd_mux = L_DW'(adc_rdata);
      DAC_SEL:   rd_mux = L_DW'(dac_sel);
      DAC_WDATA: rd_mux = dac_wdata;
      DAC_TASK:  rd_mux = L_DW'(dac_ser.req);
      DAC_RDATA: rd_mux = dac_rdata;
      LTC_LO:    rd_mux = i_ltc[31:0];
      LTC_HI:    rd_mux = L_DW'(i_ltc_hi_snap);
      default:   rd_resp = RESP_SLVERR;
    endcase
  end

  // bus handshakes, control registers, task requests
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_awready <= 1'b0;
      o_bvalid <= 1'b0;
      o_bresp <= RESP_OKAY;
      o_rvalid <= 1'b0;
      o_rresp <= RESP_OKAY;
      o_adc_reset <= 1'b0;
      adc_sel <= '0;
      dac_sel <= '0;
      adc_ser.req <= 1'b0;
      dac_ser.req <= 1'b0;
    end else begin
      // ready pulses one cycle, held off while a response waits
      o_awready <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;
      if (aw_go) begin
        o_bvalid <= 1'b1;
        o_bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (ar_go) begin
        o_rvalid <= 1'b1;
        o_rresp <= rd_resp;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
      if (aw_go && !wr_err) begin
        case (reg_addr_e'(i_awaddr))
          ADC_RESET: o_adc_reset <= i_wdata[0];
          ADC_SEL:   adc_sel <= spi_tgt_t'(i_wdata);
          DAC_SEL:   dac_sel <= spi_tgt_t'(i_wdata);
          default:   o_adc_reset <= o_adc_reset;
        endcase
      end
      if (adc_start) begin
        adc_ser.req <= 1'b1;
      end else if (adc_ser.ack) begin
        adc_ser.req <= 1'b0;
      end
      if (dac_start) begin
        dac_ser.req <= 1'b1;
      end else if (dac_ser.ack) begin
        dac_ser.req <= 1'b0;
      end
    end
  end

  // data words, frame targets and readback
  always_ff @(posedge lclk) begin
    if (ar_go) begin
      o_rdata <= rd_mux;
    end
    if (aw_go && (i_awaddr == ADC_WDATA)) begin
      adc_wdata <= i_wdata;
    end
    if (aw_go && (i_awaddr == DAC_WDATA)) begin
      dac_wdata <= i_wdata;
    end
    // frozen for the whole frame
    if (adc_start) begin
      adc_ser.target <= adc_sel;
      adc_ser.wr_data <= adc_wdata;
    end
    if (dac_start) begin
      dac_ser.target <= dac_sel;
      dac_ser.wr_data <= dac_wdata;
    end
    // adc returns its register byte last
    if (adc_ser.ack) begin
      adc_rdata <= adc_ser.rd_data[7:0];
    end
    if (dac_ser.ack) begin
      dac_rdata <= dac_ser.rd_data;
    end
  end

  a_bvalid_hold: assert property (@(posedge lclk) disable iff (lclk_rst)
    o_bvalid && !i_bready |=> o_bvalid);

  // a new task never starts on the ack of the last one
  a_adc_req_ack: assert property (@(posedge lclk) disable iff (lclk_rst)
    $rose(adc_ser.req) |-> !adc_ser.ack);
  a_dac_req_ack: assert property (@(posedge lclk) disable iff (lclk_rst)
    $rose(dac_ser.req) |-> !dac_ser.ack);

endmodule

//--- src/mdom_top.sv
// mainboard slow-control top level
// AXI4-Lite register bank, adc and dac serial engines, time counter, LEDs
`timescale 1ns/1ps
`include "mdom_defs.svh"

module mdom_top (
  input  logic                        i_lclk,
  input  logic                        i_lclk_rst,
  // register bus
  input  logic [`MDOM_AXI_ADDR_W-1:0] i_awaddr,
  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  logic [`MDOM_AXI_DATA_W-1:0] i_wdata,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  output logic [1:0]                  o_bresp,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  input  logic [`MDOM_AXI_ADDR_W-1:0] i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_arready,
  output logic [`MDOM_AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]                  o_rresp,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  // adc serial bus, shared by all six chips
  output logic                        o_adc_reset,
  output logic                        o_adc_sclk,
  output logic                        o_adc_sdata,
  output logic [`MDOM_N_ADC-1:0]      o_adc_sen_n,
  input  logic                        i_adc_sdout,
  // dac serial bus
  output logic                        o_dac_sclk,
  output logic                        o_dac_din,
  output logic [`MDOM_N_DAC_SYNC-1:0] o_dac_sync_n,
  input  logic                        i_dac_sdo,
  output logic [`MDOM_N_LED-1:0]      o_led
);

  wire lclk = i_lclk;
  wire lclk_rst = i_lclk_rst;

  wire ltc_snap;
  wire [`MDOM_LTC_W-1:0] ltc;
  wire [15:0] ltc_hi_snap;

  serial_ctrl_if adc_ser ();
  serial_ctrl_if dac_ser ();

  mdom_ctrl_regs CTRL_REGS (
    .lclk          (lclk),
    .lclk_rst      (lclk_rst),
    .i_awaddr      (i_awaddr),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_wdata       (i_wdata),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_bresp       (o_bresp),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .i_araddr      (i_araddr),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .o_adc_reset   (o_adc_reset),
    .o_ltc_snap    (ltc_snap),
    .i_ltc         (ltc),
    .i_ltc_hi_snap (ltc_hi_snap),
    .adc_ser       (adc_ser.ctrl),
    .dac_ser       (dac_ser.ctrl)
  );

  // adc3424, sclk idle low
  spi_master #(
    .P_BITS (`MDOM_ADC_SPI_BITS),
    .P_N_CS (`MDOM_N_ADC),
    .P_CPOL (1'b0)
  ) ADC_SPI (
    .lclk     (lclk),
    .lclk_rst (lclk_rst),
    .ser      (adc_ser.engine),
    .i_miso   (i_adc_sdout),
    .o_sclk   (o_adc_sclk),
    .o_mosi   (o_adc_sdata),
    .o_cs_n   (o_adc_sen_n)
  );

  // ad5668, sclk idle high
  spi_master #(
    .P_BITS (`MDOM_DAC_SPI_BITS),
    .P_N_CS (`MDOM_N_DAC_SYNC),
    .P_CPOL (1'b1)
  ) DAC_SPI (
    .lclk     (lclk),
    .lclk_rst (lclk_rst),
    .ser      (dac_ser.engine),
    .i_miso   (i_dac_sdo),
    .o_sclk   (o_dac_sclk),
    .o_mosi   (o_dac_din),
    .o_cs_n   (o_dac_sync_n)
  );

  ltc_counter LTC_0 (
    .lclk          (lclk),
    .lclk_rst      (lclk_rst),
    .i_snap        (ltc_snap),
    .o_ltc         (ltc),
    .o_ltc_hi_snap (ltc_hi_snap)
  );

  led_sweep LED_0 (
    .lclk     (lclk),
    .lclk_rst (lclk_rst),
    .o_led    (o_led)
  );

endmodule

//--- verification/tb_mdom_top.sv
// testbench for the mainboard slow-control top level
// AXI4-Lite tasks, serial loopbacks, assertion checks and a watchdog
`timescale 1ns/1ps
`include "mdom_defs.svh"

module tb_mdom_top;
  import mdom_reg_pkg::*;

  // serial frame lengths in lclk cycles, setup + bits + done
  localparam int L_ADC_FRAME = `MDOM_SPI_HALF * (1 + 2 * `MDOM_ADC_SPI_BITS) + 1;
  localparam int L_DAC_FRAME = `MDOM_SPI_HALF * (1 + 2 * `MDOM_DAC_SPI_BITS) + 1;
  localparam int L_AXI_CYC = 8;
  localparam int L_N_AXI = 40;
  localparam int L_WD_CYCLES = 2 * (10 + L_ADC_FRAME + L_DAC_FRAME +
                                    L_N_AXI * L_AXI_CYC + 4 * `MDOM_LED_STEP);
  localparam int L_HS_LIMIT = 50;

  logic lclk;
  logic lclk_rst;
  logic [`MDOM_AXI_ADDR_W-1:0] i_awaddr;
  logic i_awvalid;
  logic o_awready;
  logic [`MDOM_AXI_DATA_W-1:0] i_wdata;
  logic i_wvalid;
  logic o_wready;
  logic [1:0] o_bresp;
  logic o_bvalid;
  logic i_bready;
  logic [`MDOM_AXI_ADDR_W-1:0] i_araddr;
  logic i_arvalid;
  logic o_arready;
  logic [`MDOM_AXI_DATA_W-1:0] o_rdata;
  logic [1:0] o_rresp;
  logic o_rvalid;
  logic i_rready;
  logic o_adc_reset;
  logic o_adc_sclk;
  logic o_adc_sdata;
  logic [`MDOM_N_ADC-1:0] o_adc_sen_n;
  logic i_adc_sdout;
  logic o_dac_sclk;
  logic o_dac_din;
  logic [`MDOM_N_DAC_SYNC-1:0] o_dac_sync_n;
  logic i_dac_sdo;
  logic [`MDOM_N_LED-1:0] o_led;

  int val_errs;
  int misc_errs;
  string test_name;
  int adc_tgt_exp;
  int dac_tgt_exp;
  logic adc_sel_seen;
  logic dac_sel_seen;
  logic [`MDOM_N_LED-1:0] led_prev;
  int led_still;

  // serial loopbacks, readback equals the word sent
  assign i_adc_sdout = o_adc_sdata;
  assign i_dac_sdo = o_dac_din;

  mdom_top UUT (
    .i_lclk (lclk), .i_lclk_rst (lclk_rst),
    .i_awaddr (i_awaddr), .i_awvalid (i_awvalid), .o_awready (o_awready),
    .i_wdata (i_wdata), .i_wvalid (i_wvalid), .o_wready (o_wready),
    .o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
    .i_araddr (i_araddr), .i_arvalid (i_arvalid), .o_arready (o_arready),
    .o_rdata (o_rdata), .o_rresp (o_rresp), .o_rvalid (o_rvalid), .i_rready (i_rready),
    .o_adc_reset (o_adc_reset), .o_adc_sclk (o_adc_sclk), .o_adc_sdata (o_adc_sdata),
    .o_adc_sen_n (o_adc_sen_n), .i_adc_sdout (i_adc_sdout),
    .o_dac_sclk (o_dac_sclk), .o_dac_din (o_dac_din),
    .o_dac_sync_n (o_dac_sync_n), .i_dac_sdo (i_dac_sdo), .o_led (o_led)
  );

  initial lclk = 1'b0;
  always #50 lclk = ~lclk;

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      val_errs++;
      $display("FAIL %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // called and left 5 ns after a rising edge
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    n = 0;
    i_awaddr = addr;
    i_wdata = data;
    i_awvalid = 1'b1;
    i_wvalid = 1'b1;
    @(posedge lclk);
    while (!o_awready && n < L_HS_LIMIT) begin
      @(posedge lclk);
      n++;
    end
    if (n >= L_HS_LIMIT) begin
      misc_errs++;
      $display("write to address %h was never accepted", addr);
    end
    #5;
    i_awvalid = 1'b0;
    i_wvalid = 1'b0;
    n = 0;
    @(posedge lclk);
    while (!o_bvalid && n < L_HS_LIMIT) begin
      @(posedge lclk);
      n++;
    end
    if (n >= L_HS_LIMIT) begin
      misc_errs++;
      $display("write to address %h got no response", addr);
    end
    resp = o_bresp;
    #5;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    n = 0;
    i_araddr = addr;
    i_arvalid = 1'b1;
    @(posedge lclk);
    while (!o_arready && n < L_HS_LIMIT) begin
      @(posedge lclk);
      n++;
    end
    #5;
    i_arvalid = 1'b0;
    n = 0;
    @(posedge lclk);
    while (!o_rvalid && n < L_HS_LIMIT) begin
      @(posedge lclk);
      n++;
    end
    if (n >= L_HS_LIMIT) begin
      misc_errs++;
      $display("read of address %h got no response", addr);
    end
    data = o_rdata;
    resp = o_rresp;
    #5;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string what);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value({what, " bresp"}, 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp, input string what);
    logic [31:0] data;
    logic [1:0] resp;
    axi_read(addr, data, resp);
    check_value({what, " rresp"}, 32'(exp_resp), 32'(resp));
    check_value({what, " rdata"}, exp_data, data);
  endtask

  // poll a task register until the busy bit drops
  task automatic wait_task_idle(input logic [7:0] addr);
    logic [31:0] data;
    logic [1:0] resp;
    int polls;
    polls = 0;
    data = 32'd1;
    while (data[0] && polls < 200) begin
      axi_read(addr, data, resp);
      polls++;
    end
    if (data[0]) begin
      misc_errs++;
      $display("serial frame at task address %h never finished", addr);
    end
  endtask

  task automatic read_time(output logic [47:0] t);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [1:0] resp;
    axi_read(LTC_LO, lo, resp);
    check_value("LTC_LO rresp", 32'(RESP_OKAY), 32'(resp));
    axi_read(LTC_HI, hi, resp);
    check_value("LTC_HI rresp", 32'(RESP_OKAY), 32'(resp));
    t = {hi[15:0], lo};
  endtask

  // write address and data ready pulse as a pair
  a_wready_pair: assert property (@(posedge lclk) disable iff (lclk_rst)
    o_wready == o_awready)
    else begin
      misc_errs++;
      $display("write data ready did not pulse together with write address ready");
    end

  // serial bus checks
  a_adc_idle: assert property (@(posedge lclk) disable iff (lclk_rst)
    &o_adc_sen_n |-> !o_adc_sclk)
    else begin
      misc_errs++;
      $display("ADC serial clock left its idle level with no enable low");
    end
  a_dac_idle: assert property (@(posedge lclk) disable iff (lclk_rst)
    &o_dac_sync_n |-> o_dac_sclk)
    else begin
      misc_errs++;
      $display("DAC serial clock left its idle level with no sync low");
    end
  a_adc_only_tgt: assert property (@(posedge lclk) disable iff (lclk_rst)
    !(&o_adc_sen_n) |-> (o_adc_sen_n == ~(`MDOM_N_ADC'(1) << adc_tgt_exp)))
    else begin
      val_errs++;
      $display("FAIL %s: adc enables expected %b, actual %b", test_name,
               ~(`MDOM_N_ADC'(1) << adc_tgt_exp), $sampled(o_adc_sen_n));
    end
  a_dac_only_tgt: assert property (@(posedge lclk) disable iff (lclk_rst)
    !(&o_dac_sync_n) |-> (o_dac_sync_n == ~(`MDOM_N_DAC_SYNC'(1) << dac_tgt_exp)))
    else begin
      val_errs++;
      $display("FAIL %s: dac syncs expected %b, actual %b", test_name,
               ~(`MDOM_N_DAC_SYNC'(1) << dac_tgt_exp), $sampled(o_dac_sync_n));
    end
  a_led_onehot: assert property (@(posedge lclk) disable iff (lclk_rst) $onehot(o_led))
    else begin
      misc_errs++;
      $display("LED pattern is not one-hot");
    end

  // selected chip must actually be enabled during the frame
  always @(posedge lclk) begin
    if (!o_adc_sen_n[adc_tgt_exp]) adc_sel_seen = 1'b1;
    if (!o_dac_sync_n[dac_tgt_exp]) dac_sel_seen = 1'b1;
  end

  // lit LED has to move within two steps
  always @(posedge lclk) begin
    if (lclk_rst || (o_led !== led_prev)) begin
      led_still = 0;
    end else begin
      led_still++;
    end
    led_prev = o_led;
    assert (led_still < 2 * `MDOM_LED_STEP) else begin
      misc_errs++;
      $display("LED position stuck for %0d cycles", led_still);
    end
  end

  // watchdog
  initial begin
    #(L_WD_CYCLES * 100);
    $display("run timed out after %0d cycles", L_WD_CYCLES);
    $display("errors: %0d value, %0d other", val_errs, misc_errs);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] adc_word;
    logic [31:0] dac_word;
    int adc_tgt;
    int dac_tgt;
    logic [47:0] t0;
    logic [47:0] t1;
    void'($urandom(32'h7504_46f9));
    val_errs = 0;
    misc_errs = 0;
    test_name = "reset";
    adc_tgt_exp = 0;
    dac_tgt_exp = 0;
    adc_sel_seen = 1'b0;
    dac_sel_seen = 1'b0;
    led_prev = '0;
    led_still = 0;
    lclk_rst = 1'b1;
    i_awaddr = '0;
    i_awvalid = 1'b0;
    i_wdata = '0;
    i_wvalid = 1'b0;
    i_bready = 1'b1;
    i_araddr = '0;
    i_arvalid = 1'b0;
    i_rready = 1'b1;
    repeat (10) @(posedge lclk);
    #5;
    lclk_rst = 1'b0;

    // idle levels and fixed registers
    check_value("led after reset", 32'd1, 32'(o_led));
    check_value("adc enables", 32'(`MDOM_N_ADC'('1)), 32'(o_adc_sen_n));
    check_value("dac syncs", 32'(`MDOM_N_DAC_SYNC'('1)), 32'(o_dac_sync_n));
    check_value("adc sclk idle", 32'd0, 32'(o_adc_sclk));
    check_value("dac sclk idle", 32'd1, 32'(o_dac_sclk));
    read_expect(VERSION, `MDOM_FW_VNUM, RESP_OKAY, "VERSION");
    read_expect(8'h30, 32'd0, RESP_SLVERR, "unmapped read");

    test_name = "adc_frame";
    adc_tgt = $urandom % `MDOM_N_ADC;
    adc_word = $urandom & 32'h00FF_FFFF;
    write_expect(ADC_SEL, 32'(adc_tgt), RESP_OKAY, "ADC_SEL");
    write_expect(ADC_WDATA, adc_word, RESP_OKAY, "ADC_WDATA");
    adc_tgt_exp = adc_tgt;
    adc_sel_seen = 1'b0;
    write_expect(ADC_TASK, 32'd1, RESP_OKAY, "ADC_TASK start");
    read_expect(ADC_TASK, 32'd1, RESP_OKAY, "ADC_TASK busy");
    test_name = "busy_reject";
    write_expect(ADC_TASK, 32'd1, RESP_SLVERR, "ADC_TASK while busy");
    read_expect(ADC_SEL, 32'(adc_tgt), RESP_OKAY, "ADC_SEL after busy reject");
    test_name = "adc_frame";
    wait_task_idle(ADC_TASK);
    check_value("selected adc enable low", 32'd1, 32'(adc_sel_seen));
    read_expect(ADC_RDATA, {24'h0, adc_word[7:0]}, RESP_OKAY, "ADC_RDATA");

    test_name = "dac_frame";
    dac_tgt = $urandom % `MDOM_N_DAC_SYNC;
    dac_word = $urandom;
    write_expect(DAC_SEL, 32'(dac_tgt), RESP_OKAY, "DAC_SEL");
    write_expect(DAC_WDATA, dac_word, RESP_OKAY, "DAC_WDATA");
    dac_tgt_exp = dac_tgt;
    dac_sel_seen = 1'b0;
    write_expect(DAC_TASK, 32'd1, RESP_OKAY, "DAC_TASK start");
    read_expect(DAC_TASK, 32'd1, RESP_OKAY, "DAC_TASK busy");
    wait_task_idle(DAC_TASK);
    check_value("selected dac sync low", 32'd1, 32'(dac_sel_seen));
    read_expect(DAC_RDATA, dac_word, RESP_OKAY, "DAC_RDATA");

    // out-of-range selects leave the old target
    test_name = "illegal_sel";
    write_expect(ADC_SEL, 32'd7, RESP_SLVERR, "ADC_SEL 7");
    read_expect(ADC_SEL, 32'(adc_tgt), RESP_OKAY, "ADC_SEL kept");
    write_expect(DAC_SEL, 32'd12, RESP_SLVERR, "DAC_SEL 12");
    read_expect(DAC_SEL, 32'(dac_tgt), RESP_OKAY, "DAC_SEL kept");

    test_name = "time_counter";
    read_time(t0);
    read_time(t1);
    assert (t1 > t0) else begin
      val_errs++;
      $display("FAIL %s: time expected above %h, actual %h", test_name, t0, t1);
    end

    test_name = "adc_reset";
    write_expect(ADC_RESET, 32'd1, RESP_OKAY, "ADC_RESET set");
    read_expect(ADC_RESET, 32'd1, RESP_OKAY, "ADC_RESET set");
    check_value("adc reset pin", 32'd1, 32'(o_adc_reset));
    write_expect(ADC_RESET, 32'd0, RESP_OKAY, "ADC_RESET clear");
    read_expect(ADC_RESET, 32'd0, RESP_OKAY, "ADC_RESET clear");
    check_value("adc reset pin", 32'd0, 32'(o_adc_reset));

    // let the LED monitor see a few steps and a turn
    test_name = "led_sweep";
    repeat (4 * `MDOM_LED_STEP) @(posedge lclk);
    #5;

    $display("errors: %0d value, %0d other", val_errs, misc_errs);
    if (val_errs == 0 && misc_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/mdom_reg_pkg.sv
src/mdom_serial_pkg.sv
src/serial_ctrl_if.sv
src/ltc_counter.sv
src/led_sweep.sv
src/spi_master.sv
src/mdom_ctrl_regs.sv
src/mdom_top.sv
verification/tb_mdom_top.sv

//--- Bender.yml
package:
  name: mdom_slow_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/mdom_reg_pkg.sv
      - src/mdom_serial_pkg.sv
      - src/serial_ctrl_if.sv
      - src/ltc_counter.sv
      - src/led_sweep.sv
      - src/spi_master.sv
      - src/mdom_ctrl_regs.sv
      - src/mdom_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_mdom_top.sv
